//--- write_buffer.f
+incdir+include
source/wbuf_ctrl_pkg.sv
source/mem_wr_pkg.sv
source/wbuf_store.sv
source/wbuf_drain_fsm.sv
source/wbuf_beat_counter.sv
source/write_buffer.sv
testbench/wbuf_checker.sv
testbench/tb_write_buffer.sv

//--- run.sh
#!/bin/sh
# builds the write buffer testbench with Verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f write_buffer.f --top-module tb_write_buffer -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished without failure"

//--- testbench/tb_write_buffer.sv
// memory model stalls at random and answers one burst at a time; test names hold up to 16 chars
`timescale 1ns/1ps
`default_nettype none

`include "wbuf_macros.svh"

module tb_write_buffer
    import mem_wr_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int NUM_ROWS   = 21;

    typedef enum logic [2:0] {ACT_PUSH, ACT_QUERY, ACT_LOCK, ACT_UNLOCK, ACT_ERROR} act_e;

    typedef struct packed {
        logic [127:0]            name;
        act_e                    act;
        logic [`WBUF_ADDR_W-1:0] addr;
        logic [15:0]             seed;
    } row_t;

    logic                    clk = 1'b0;
    logic                    rstn;
    logic                    in_valid;
    logic [`WBUF_ADDR_W-1:0] in_addr;
    line_t                   in_line;
    logic [`WBUF_ADDR_W-1:0] query_addr;
    logic                    dma_lock;
    logic                    aw_ready = 1'b0;
    logic                    w_ready = 1'b0;
    logic                    b_valid = 1'b0;
    wr_resp_e                b_resp = RESP_OKAY;
    logic                    in_ready;
    logic                    query_hit;
    line_t                   query_line;
    logic                    wrt_lock;
    logic                    aw_valid;
    logic [`WBUF_ADDR_W-1:0] aw_addr;
    logic                    w_valid;
    word_t                   w_data;
    logic                    w_last;
    logic                    b_ready;
    logic [127:0]            test_name;
    logic                    query_en;
    int                      value_errs;
    int                      other_errs;
    int                      model_count;
    logic                    resp_pending = 1'b0;
    int                      err_req = 0;
    int                      err_done = 0;
    row_t                    rows [NUM_ROWS];

    write_buffer dut (.*);

    wbuf_checker chk (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic line_t make_line(input logic [15:0] seed);
        line_t line;
        for (int w = 0; w < `WBUF_BEATS; w++) begin
            line[w*`WBUF_WORD_W +: `WBUF_WORD_W] = {seed, 16'(w)} ^ $urandom;
        end
        return line;
    endfunction

    // returns on the edge after the handshake
    task automatic push_line(input logic [`WBUF_ADDR_W-1:0] addr, input line_t line);
        in_valid <= 1'b1;
        in_addr  <= addr;
        in_line  <= line;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic run_query(input logic [`WBUF_ADDR_W-1:0] addr);
        query_addr <= addr;
        query_en   <= 1'b1;
        @(posedge clk);
        query_en <= 1'b0;
    endtask

    // armed error turns the next response into SLVERR
    always @(posedge clk) begin
        if (!rstn) begin
            aw_ready     <= 1'b0;
            w_ready      <= 1'b0;
            b_valid      <= 1'b0;
            resp_pending <= 1'b0;
        end else begin
            aw_ready <= ($urandom % 4) != 0;
            w_ready  <= ($urandom % 4) != 0;
            if (w_valid && w_ready && w_last) begin
                resp_pending <= 1'b1;
            end
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end else if (resp_pending && !b_valid && ($urandom % 2) == 0) begin
                b_valid      <= 1'b1;
                resp_pending <= 1'b0;
                b_resp       <= (err_req != err_done) ? RESP_SLVERR : RESP_OKAY;
                if (err_req != err_done) begin
                    err_done <= err_done + 1;
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h225bbb62));
        rstn       = 1'b0;
        in_valid   = 1'b0;
        in_addr    = '0;
        in_line    = '0;
        query_addr = '0;
        query_en   = 1'b0;
        dma_lock   = 1'b0;
        test_name  = "reset";
        rows = '{
            '{"lock_on",         ACT_LOCK,   32'h0000, 16'h0000},
            '{"push_a",          ACT_PUSH,   32'h1000, 16'h00a1},
            '{"push_b",          ACT_PUSH,   32'h2000, 16'h00b2},
            '{"push_c",          ACT_PUSH,   32'h3000, 16'h00c3},
            '{"query_a",         ACT_QUERY,  32'h1000, 16'h0000},
            '{"query_c",         ACT_QUERY,  32'h3000, 16'h0000},
            '{"query_miss",      ACT_QUERY,  32'h9000, 16'h0000},
            '{"push_b_again",    ACT_PUSH,   32'h2000, 16'h00b7},
            '{"query_b_newest",  ACT_QUERY,  32'h2000, 16'h0000},
            '{"push_d",          ACT_PUSH,   32'h4000, 16'h00d4},
            '{"query_full",      ACT_QUERY,  32'h4000, 16'h0000},
            '{"arm_error",       ACT_ERROR,  32'h0000, 16'h0000},
            '{"lock_off",        ACT_UNLOCK, 32'h0000, 16'h0000},
            '{"query_in_flight", ACT_QUERY,  32'h1000, 16'h0000},
            '{"push_e",          ACT_PUSH,   32'h5000, 16'h00e5},
            '{"query_a_gone",    ACT_QUERY,  32'h1000, 16'h0000},
            '{"lock_on_again",   ACT_LOCK,   32'h0000, 16'h0000},
            '{"query_e",         ACT_QUERY,  32'h5000, 16'h0000},
            '{"lock_off_again",  ACT_UNLOCK, 32'h0000, 16'h0000},
            '{"push_f",          ACT_PUSH,   32'h6000, 16'h00f6},
            '{"query_f",         ACT_QUERY,  32'h6000, 16'h0000}
        };
        repeat (8) @(posedge clk);
        rstn <= 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk);
            test_name <= rows[r].name;
            case (rows[r].act)
                ACT_PUSH:   push_line(rows[r].addr, make_line(rows[r].seed));
                ACT_QUERY:  run_query(rows[r].addr);
                ACT_LOCK:   dma_lock <= 1'b1;
                ACT_UNLOCK: dma_lock <= 1'b0;
                ACT_ERROR:  err_req <= err_req + 1;
                default:    ;
            endcase
        end

        // let every remaining line drain before closing
        @(posedge clk);
        test_name <= "final_drain";
        dma_lock  <= 1'b0;
        @(negedge clk);
        while (model_count != 0 || wrt_lock) @(negedge clk);
        repeat (2) @(posedge clk);

        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // 40 clock cycles per table row
    initial begin
        #(NUM_ROWS * 40 * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", NUM_ROWS * 40);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/wbuf_checker.sv
// model assumes one burst in flight; outputs are sampled on the rising edge before they change
`timescale 1ns/1ps
`default_nettype none

`include "wbuf_macros.svh"

module wbuf_checker
    import mem_wr_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic [127:0]            test_name,
    input  wire logic                    query_en,
    input  wire logic                    in_valid,
    input  wire logic                    in_ready,
    input  wire logic [`WBUF_ADDR_W-1:0] in_addr,
    input  wire line_t                   in_line,
    input  wire logic [`WBUF_ADDR_W-1:0] query_addr,
    input  wire logic                    query_hit,
    input  wire line_t                   query_line,
    input  wire logic                    dma_lock,
    input  wire logic                    wrt_lock,
    input  wire logic                    aw_valid,
    input  wire logic                    aw_ready,
    input  wire logic [`WBUF_ADDR_W-1:0] aw_addr,
    input  wire logic                    w_valid,
    input  wire logic                    w_ready,
    input  wire word_t                   w_data,
    input  wire logic                    w_last,
    input  wire logic                    b_valid,
    input  wire logic                    b_ready,
    input  wire wr_resp_e                b_resp,
    output int                           value_errs,
    output int                           other_errs,
    output int                           model_count
);

    // index 0 is the newest line and the back of the queue the oldest
    logic [`WBUF_ADDR_W-1:0] model_addr [$];
    line_t                   model_line [$];
    int                      beat_idx = 0;
    logic                    idle_locked = 1'b0;
    logic                    in_reset = 1'b0;

    always @(posedge clk) begin
        logic  exp_hit;
        logic  exp_ready;
        logic  exp_last;
        line_t exp_line;
        word_t exp_word;
        if (!rstn) begin
            if (in_reset && (wrt_lock || aw_valid || w_valid || b_ready || query_hit)) begin
                $display("reset check failed: a DUT output is high while reset is held");
                other_errs++;
            end
            in_reset    <= 1'b1;
            idle_locked <= 1'b0;
            beat_idx = 0;
            model_addr.delete();
            model_line.delete();
        end else begin
            if (query_en) begin
                exp_hit  = 1'b0;
                exp_line = '0;
                foreach (model_addr[i]) begin
                    if (!exp_hit && model_addr[i] == query_addr) begin
                        exp_hit  = 1'b1;
                        exp_line = model_line[i];
                    end
                end
                if (query_hit !== exp_hit) begin
                    $display("[ERROR] %0s: query_hit expected %0b, actual %0b",
                             test_name, exp_hit, query_hit);
                    value_errs++;
                end else if (exp_hit && query_line !== exp_line) begin
                    $display("[ERROR] %0s: query_line expected %h, actual %h",
                             test_name, exp_line, query_line);
                    value_errs++;
                end
            end

            exp_ready = (model_addr.size() < `WBUF_DEPTH);
            if (in_ready !== exp_ready) begin
                $display("[ERROR] %0s: in_ready expected %0b, actual %0b",
                         test_name, exp_ready, in_ready);
                value_errs++;
            end

            // lock ownership
            if ((aw_valid || w_valid || b_ready) && !wrt_lock) begin
                $display("lock check failed in %0s: write channel active without wrt_lock",
                         test_name);
                other_errs++;
            end
            if (aw_valid && idle_locked) begin
                $display("lock check failed in %0s: burst started while the DMA held the lock",
                         test_name);
                other_errs++;
            end
            idle_locked <= !wrt_lock && dma_lock;

            if (aw_valid && aw_ready) begin
                beat_idx = 0;
                if (model_addr.size() == 0) begin
                    $display("burst check failed in %0s: burst issued from an empty buffer",
                             test_name);
                    other_errs++;
                end else if (aw_addr !== model_addr[$]) begin
                    $display("[ERROR] %0s: aw_addr expected %h, actual %h",
                             test_name, model_addr[$], aw_addr);
                    value_errs++;
                end
            end

            if (w_valid && w_ready) begin
                if (beat_idx >= `WBUF_BEATS || model_line.size() == 0) begin
                    $display("burst check failed in %0s: data beat outside a valid burst",
                             test_name);
                    other_errs++;
                end else begin
                    exp_line = model_line[$];
                    exp_word = exp_line[beat_idx*`WBUF_WORD_W +: `WBUF_WORD_W];
                    exp_last = (beat_idx == `WBUF_BEATS - 1);
                    if (w_data !== exp_word) begin
                        $display("[ERROR] %0s: w_data beat %0d expected %h, actual %h",
                                 test_name, beat_idx, exp_word, w_data);
                        value_errs++;
                    end
                    if (w_last !== exp_last) begin
                        $display("[ERROR] %0s: w_last beat %0d expected %0b, actual %0b",
                                 test_name, beat_idx, exp_last, w_last);
                        value_errs++;
                    end
                end
                beat_idx++;
            end

            if (b_valid && b_ready) begin
                if (beat_idx != `WBUF_BEATS) begin
                    $display("burst check failed in %0s: response taken after %0d beats",
                             test_name, beat_idx);
                    other_errs++;
                end
                // an error response keeps the line for the replay
                if (b_resp == RESP_OKAY && model_addr.size() != 0) begin
                    void'(model_addr.pop_back());
                    void'(model_line.pop_back());
                end
            end

            if (in_valid && in_ready) begin
                model_addr.push_front(in_addr);
                model_line.push_front(in_line);
            end
        end
        model_count <= model_addr.size();
    end

endmodule

`default_nettype wire

//--- source/write_buffer.sv
// w_data and w_last are only meaningful while w_valid is high; the cache holds its inputs while in_ready is low
`timescale 1ns/1ps
`default_nettype none

`include "wbuf_macros.svh"

module write_buffer
    import mem_wr_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic                    in_valid,
    input  wire logic [`WBUF_ADDR_W-1:0] in_addr,
    input  wire line_t                   in_line,
    input  wire logic [`WBUF_ADDR_W-1:0] query_addr,
    input  wire logic                    dma_lock,
    input  wire logic                    aw_ready,
    input  wire logic                    w_ready,
    input  wire logic                    b_valid,
    input  wire wr_resp_e                b_resp,
    output logic                         in_ready,
    output logic                         query_hit,
    output line_t                        query_line,
    output logic                         wrt_lock,
    output logic                         aw_valid,
    output logic [`WBUF_ADDR_W-1:0]      aw_addr,
    output logic                         w_valid,
    output word_t                        w_data,
    output logic                         w_last,
    output logic                         b_ready
);

    logic [`WBUF_OCC_W-1:0]  occupancy;
    logic [`WBUF_ADDR_W-1:0] tail_addr;
    line_t                   tail_line;
    logic                    pop;
    logic                    capture;
    logic                    beat_advance;
    logic                    rewind;

    wbuf_store u_store (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .in_addr    (in_addr),
        .in_line    (in_line),
        .pop        (pop),
        .query_addr (query_addr),
        .in_ready   (in_ready),
        .occupancy  (occupancy),
        .tail_addr  (tail_addr),
        .tail_line  (tail_line),
        .query_hit  (query_hit),
        .query_line (query_line)
    );

    wbuf_drain_fsm u_drain_fsm (
        .clk          (clk),
        .rstn         (rstn),
        .occupancy    (occupancy),
        .tail_addr    (tail_addr),
        .dma_lock     (dma_lock),
        .aw_ready     (aw_ready),
        .w_ready      (w_ready),
        .beat_last    (w_last),
        .b_valid      (b_valid),
        .b_resp       (b_resp),
        .capture      (capture),
        .beat_advance (beat_advance),
        .rewind       (rewind),
        .aw_valid     (aw_valid),
        .aw_addr      (aw_addr),
        .w_valid      (w_valid),
        .b_ready      (b_ready),
        .pop          (pop),
        .wrt_lock     (wrt_lock)
    );

    // w_last is the counter's last-beat flag
    wbuf_beat_counter u_beat_counter (
        .clk          (clk),
        .rstn         (rstn),
        .capture      (capture),
        .tail_line    (tail_line),
        .beat_advance (beat_advance),
        .rewind       (rewind),
        .w_data       (w_data),
        .beat_last    (w_last)
    );

endmodule

`default_nettype wire

//--- source/wbuf_beat_counter.sv
// holds its own copy of the line so a store shifting under it cannot change a replay
`timescale 1ns/1ps
`default_nettype none

`include "wbuf_macros.svh"

module wbuf_beat_counter
    import mem_wr_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rstn,
    input  wire logic  capture,
    input  wire line_t tail_line,
    input  wire logic  beat_advance,
    input  wire logic  rewind,
    output word_t      w_data,
    output logic       beat_last
);

    localparam int CNT_W = $clog2(`WBUF_BEATS);

    line_t              line_q;
    logic [CNT_W-1:0]   beat_cnt;

    always_ff @(posedge clk) begin
        if (capture) begin
            line_q <= tail_line;
        end
    end

    // count wraps after the last beat as well
    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_cnt <= '0;
        end else if (capture || rewind) begin
            beat_cnt <= '0;
        end else if (beat_advance) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // lowest word goes first
    assign w_data    = line_q[beat_cnt*`WBUF_WORD_W +: `WBUF_WORD_W];
    assign beat_last = (beat_cnt == CNT_W'(`WBUF_BEATS - 1));

endmodule

`default_nettype wire

//--- source/wbuf_drain_fsm.sv
// one burst in flight at a time; any response other than OKAY replays the captured line
`timescale 1ns/1ps
`default_nettype none

`include "wbuf_macros.svh"

module wbuf_drain_fsm
    import mem_wr_pkg::*;
    import wbuf_ctrl_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic [`WBUF_OCC_W-1:0]  occupancy,
    input  wire logic [`WBUF_ADDR_W-1:0] tail_addr,
    input  wire logic                    dma_lock,
    input  wire logic                    aw_ready,
    input  wire logic                    w_ready,
    input  wire logic                    beat_last,
    input  wire logic                    b_valid,
    input  wire wr_resp_e                b_resp,
    output logic                         capture,
    output logic                         beat_advance,
    output logic                         rewind,
    output logic                         aw_valid,
    output logic [`WBUF_ADDR_W-1:0]      aw_addr,
    output logic                         w_valid,
    output logic                         b_ready,
    output logic                         pop,
    output logic                         wrt_lock
);

    drain_state_e state_q;
    drain_state_e state_d;
    logic         resp_taken;

    // only start when the DMA side has let go of memory
    assign capture      = (state_q == DRAIN_IDLE) && (occupancy != '0) && !dma_lock;
    assign aw_valid     = (state_q == DRAIN_ADDR);
    assign w_valid      = (state_q == DRAIN_DATA);
    assign b_ready      = (state_q == DRAIN_RESP);
    assign beat_advance = w_valid && w_ready;
    assign resp_taken   = b_ready && b_valid;
    assign pop          = resp_taken && (b_resp == RESP_OKAY);
    assign rewind       = resp_taken && (b_resp != RESP_OKAY);
    assign wrt_lock     = (state_q != DRAIN_IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            DRAIN_IDLE: if (capture) state_d = DRAIN_ADDR;
            DRAIN_ADDR: if (aw_ready) state_d = DRAIN_DATA;
            DRAIN_DATA: if (beat_advance && beat_last) state_d = DRAIN_RESP;
            DRAIN_RESP: begin
                if (pop) begin
                    state_d = DRAIN_IDLE;
                end else if (rewind) begin
                    state_d = DRAIN_ADDR;
                end
            end
            default: state_d = DRAIN_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= DRAIN_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // address is kept across a replay
    always_ff @(posedge clk) begin
        if (capture) begin
            aw_addr <= tail_addr;
        end
    end

endmodule

`default_nettype wire

//--- source/wbuf_store.sv
// slot 0 is the newest line; pop always removes the oldest, and pop on an empty store is not allowed
`timescale 1ns/1ps
`default_nettype none

`include "wbuf_macros.svh"

module wbuf_store
    import mem_wr_pkg::*;
    import wbuf_ctrl_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic                    in_valid,
    input  wire logic [`WBUF_ADDR_W-1:0] in_addr,
    input  wire line_t                   in_line,
    input  wire logic                    pop,
    input  wire logic [`WBUF_ADDR_W-1:0] query_addr,
    output logic                         in_ready,
    output logic [`WBUF_OCC_W-1:0]       occupancy,
    output logic [`WBUF_ADDR_W-1:0]      tail_addr,
    output line_t                        tail_line,
    output logic                         query_hit,
    output line_t                        query_line
);

    logic [`WBUF_ADDR_W-1:0] slot_addr [`WBUF_DEPTH];
    line_t                   slot_line [`WBUF_DEPTH];
    logic                    push;
    store_op_e               op;

    assign in_ready = (occupancy < `WBUF_DEPTH);
    assign push     = in_valid && in_ready;

    always_comb begin
        case ({pop, push})
            2'b01:   op = OP_PUSH;
            2'b10:   op = OP_POP;
            2'b11:   op = OP_PUSH_POP;
            default: op = OP_NONE;
        endcase
    end

    // new line enters slot 0 and the rest shift up
    always_ff @(posedge clk) begin
        if (op == OP_PUSH || op == OP_PUSH_POP) begin
            slot_addr[0] <= in_addr;
            slot_line[0] <= in_line;
            for (int i = 1; i < `WBUF_DEPTH; i++) begin
                slot_addr[i] <= slot_addr[i-1];
                slot_line[i] <= slot_line[i-1];
            end
        end
    end

    // push and pop together keep the count
    always_ff @(posedge clk) begin
        if (!rstn) begin
            occupancy <= '0;
        end else begin
            case (op)
                OP_PUSH: occupancy <= occupancy + 1'b1;
                OP_POP:  occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    // oldest valid slot sits at occupancy - 1
    always_comb begin
        tail_addr = slot_addr[0];
        tail_line = slot_line[0];
        for (int i = 1; i < `WBUF_DEPTH; i++) begin
            if (int'(occupancy) == i + 1) begin
                tail_addr = slot_addr[i];
                tail_line = slot_line[i];
            end
        end
    end

    // walk from oldest to newest so the lowest slot wins
    always_comb begin
        query_hit  = 1'b0;
        query_line = '0;
        for (int i = `WBUF_DEPTH - 1; i >= 0; i--) begin
            if (i < int'(occupancy) && slot_addr[i] == query_addr) begin
                query_hit  = 1'b1;
                query_line = slot_line[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/mem_wr_pkg.sv
// memory write port types; only OKAY and SLVERR responses are modelled, anything else replays
`default_nettype none

`include "wbuf_macros.svh"

package mem_wr_pkg;

    // full cache line, word 0 in the low bits
    typedef logic [`WBUF_BEATS*`WBUF_WORD_W-1:0] line_t;

    // one data beat
    typedef logic [`WBUF_WORD_W-1:0] word_t;

    // write response, AXI style encoding
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } wr_resp_e;

endpackage

`default_nettype wire

//--- source/wbuf_ctrl_pkg.sv
// control encodings of the write buffer; every enum is 2 bits wide
`default_nettype none

package wbuf_ctrl_pkg;

    // drain sequence, one state per write channel phase
    typedef enum logic [1:0] {
        DRAIN_IDLE = 2'd0,
        DRAIN_ADDR = 2'd1,
        DRAIN_DATA = 2'd2,
        DRAIN_RESP = 2'd3
    } drain_state_e;

    // slot update per cycle, derived from push and pop
    typedef enum logic [1:0] {
        OP_NONE     = 2'd0,
        OP_PUSH     = 2'd1,
        OP_POP      = 2'd2,
        OP_PUSH_POP = 2'd3
    } store_op_e;

endpackage

`default_nettype wire

//--- include/wbuf_macros.svh
// sizes are fixed for 256-bit lines, so changing a macro here changes line_t and the burst length
`ifndef WBUF_MACROS_SVH
`define WBUF_MACROS_SVH

// line slots held by the buffer
`define WBUF_DEPTH 5

// words per line and beats per burst
`define WBUF_BEATS 8

`define WBUF_ADDR_W 32
`define WBUF_WORD_W 32

// occupancy runs from 0 up to WBUF_DEPTH inclusive
`define WBUF_OCC_W ($clog2(`WBUF_DEPTH + 1))

`endif
